/* logic/frontend_pkg.sv */
package frontend_pkg;

    typedef logic [31:0] virt_t;
    typedef logic [31:0] uint32_t;

    // address error on instruction fetch
    localparam logic [4:0] EXC_ADEL = 5'h04;

    // the only kind of entry the table learns
    localparam logic [1:0] BR_TYPE_COND = 2'd1;

    typedef struct packed {
        logic       ex;
        logic [4:0] exccode;
        logic       tlb_refill;
        logic       bd;
        virt_t      epc;
    } exception_t;

    typedef enum logic {
        Fetch_Wait,
        Fetch_Complete
    } fetch_state_t;

    typedef struct packed {
        logic [19:0] tag;
        logic [1:0]  br_type;
        logic [1:0]  count;
        logic        inst2;
        virt_t       target;
    } bht_entry_t;

    typedef struct packed {
        logic       valid;
        virt_t      pc;
        exception_t exception;
        logic       epoch;
    } prefetch_to_fetch_bus_t;

    typedef struct packed {
        logic         valid;
        fetch_state_t state;
        virt_t        pc;
        uint32_t      inst;
        logic         br_taken;
        bht_entry_t   bpu_entry;
        exception_t   exception;
        logic         epoch;
    } fetch_queue_entry_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
    } fetch_to_bpu_bus_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
        virt_t target;
        logic  taken;
    } bpu_update_t;

    typedef struct packed {
        logic       valid;
        virt_t      pc;
        uint32_t    inst;
        logic       br_taken;
        bht_entry_t bpu_entry;
        exception_t exception;
    } fetch_to_decode_bus_t;

    // from_slot2 is only raised while the delay-slot pair is still to be issued
    typedef struct packed {
        logic  valid;
        virt_t target;
        logic  from_slot2;
    } redirect_t;

endpackage

/* logic/fast_decode.sv */
`timescale 1ns/100ps

module fast_decode import frontend_pkg::*; (
    input  uint32_t inst,
    output logic    br_op
);

    logic [5:0] opcode;
    logic [4:0] rt;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign rt     = inst[20:16];
    assign funct  = inst[5:0];

    always_comb begin
        case (opcode)
            // jr, jalr
            6'b000000: br_op = funct == 6'b001000 || funct == 6'b001001;
            // bltz, bgez and the link forms
            6'b000001: br_op = rt[3:1] == 3'b000;
            // j, jal, beq, bne, blez, bgtz
            6'b000010, 6'b000011, 6'b000100,
            6'b000101, 6'b000110, 6'b000111: br_op = 1'b1;
            default: br_op = 1'b0;
        endcase
    end

endmodule

/* logic/branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor import frontend_pkg::*; #(
    parameter int BHT_ENTRIES = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  fetch_to_bpu_bus_t fetch_to_bpu_bus,
    input  bpu_update_t       bpu_update,
    output logic              br_taken,
    output virt_t             br_target,
    output bht_entry_t        bpu_entry
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    bht_entry_t             bht [BHT_ENTRIES];
    logic [BHT_ENTRIES-1:0] bht_valid;
    logic [IDX_W-1:0]       rd_idx;
    logic [IDX_W-1:0]       wr_idx;
    bht_entry_t             rd_entry;
    bht_entry_t             wr_old;
    bht_entry_t             wr_new;
    logic                   rd_hit;
    logic                   wr_hit;

    // pair pc bits above the index folded into 20 bits
    function automatic logic [19:0] tag_of(virt_t pc);
        return pc[31:12] ^ 20'(pc[11:3] >> IDX_W);
    endfunction

    assign rd_idx   = fetch_to_bpu_bus.pc[IDX_W+2:3];
    assign rd_entry = bht[rd_idx];
    assign rd_hit   = fetch_to_bpu_bus.valid && bht_valid[rd_idx]
                   && rd_entry.tag == tag_of(fetch_to_bpu_bus.pc);

    assign br_taken  = rd_hit && rd_entry.count[1];
    assign br_target = rd_entry.target;
    assign bpu_entry = rd_hit ? rd_entry : '0;

    assign wr_idx = bpu_update.pc[IDX_W+2:3];
    assign wr_old = bht[wr_idx];
    assign wr_hit = bht_valid[wr_idx] && wr_old.tag == tag_of(bpu_update.pc);

    always_comb begin
        wr_new.tag     = tag_of(bpu_update.pc);
        wr_new.br_type = BR_TYPE_COND;
        wr_new.inst2   = bpu_update.pc[2];
        wr_new.target  = bpu_update.target;
        // a fresh entry starts weakly on the side of its first outcome
        if (!wr_hit)
            wr_new.count = bpu_update.taken ? 2'd2 : 2'd1;
        else if (bpu_update.taken && wr_old.count != 2'd3)
            wr_new.count = wr_old.count + 2'd1;
        else if (!bpu_update.taken && wr_old.count != 2'd0)
            wr_new.count = wr_old.count - 2'd1;
        else
            wr_new.count = wr_old.count;
    end

    always_ff @(posedge clk) begin
        if (bpu_update.valid) begin
            bht[wr_idx] <= wr_new;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bht_valid <= '0;
        end else if (bpu_update.valid) begin
            bht_valid[wr_idx] <= 1'b1;
        end
    end

endmodule

/* logic/prefetch_stage.sv */
`timescale 1ns/100ps

module prefetch_stage import frontend_pkg::*; #(
    parameter virt_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_allowin,
    input  redirect_t              redirect,
    input  logic                   icache_addr_ok,
    output logic                   icache_req,
    output virt_t                  icache_addr,
    output logic                   pfs_to_valid,
    output prefetch_to_fetch_bus_t prefetch_to_fetch_bus1,
    output prefetch_to_fetch_bus_t prefetch_to_fetch_bus2
);

    virt_t pc;
    virt_t pc_seq;
    virt_t jump_target;
    virt_t pc1;
    virt_t pc2;
    logic  epoch;
    logic  jump_pending;
    logic  active;
    logic  req_hold;
    logic  addr_err;

    assign addr_err = pc[1:0] != 2'b00;
    assign pc1      = {pc[31:3], 1'b0, pc[1:0]};
    assign pc2      = {pc[31:3], 1'b1, pc[1:0]};
    assign pc_seq   = {pc[31:3] + 29'd1, 1'b0, pc[1:0]};

    // once raised, the request stays up until the cache takes it
    assign icache_req  = active && !addr_err && (fs_allowin || req_hold);
    assign icache_addr = {pc[31:3], 3'b000};

    // a misaligned pair bypasses the cache
    assign pfs_to_valid = icache_req && icache_addr_ok || active && addr_err && fs_allowin;

    always_comb begin
        prefetch_to_fetch_bus1 = '0;
        prefetch_to_fetch_bus1.valid             = !pc[2];
        prefetch_to_fetch_bus1.pc                = pc1;
        prefetch_to_fetch_bus1.exception.ex      = addr_err;
        prefetch_to_fetch_bus1.exception.exccode = addr_err ? EXC_ADEL : 5'h00;
        prefetch_to_fetch_bus1.exception.epc     = pc1;
        prefetch_to_fetch_bus1.epoch             = epoch;

        prefetch_to_fetch_bus2 = '0;
        prefetch_to_fetch_bus2.valid             = 1'b1;
        prefetch_to_fetch_bus2.pc                = pc2;
        prefetch_to_fetch_bus2.exception.ex      = addr_err;
        prefetch_to_fetch_bus2.exception.exccode = addr_err ? EXC_ADEL : 5'h00;
        prefetch_to_fetch_bus2.exception.epc     = pc2;
        prefetch_to_fetch_bus2.epoch             = epoch;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= RESET_PC;
            epoch        <= 1'b0;
            jump_pending <= 1'b0;
            active       <= 1'b0;
            req_hold     <= 1'b0;
        end else begin
            active   <= 1'b1;
            req_hold <= icache_req && !icache_addr_ok;
            if (redirect.valid && redirect.from_slot2) begin
                // delay-slot pair goes out first, in the old epoch
                jump_pending <= 1'b1;
            end else if (redirect.valid) begin
                pc           <= redirect.target;
                // fetch already toggled for a jump still pending
                epoch        <= epoch ^ !jump_pending;
                jump_pending <= 1'b0;
            end else if (pfs_to_valid && jump_pending) begin
                pc           <= jump_target;
                epoch        <= !epoch;
                jump_pending <= 1'b0;
            end else if (pfs_to_valid) begin
                pc <= pc_seq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.valid) begin
            jump_target <= redirect.target;
        end
    end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import frontend_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   pfs_to_valid,
    input  prefetch_to_fetch_bus_t prefetch_to_fetch_bus1,
    input  prefetch_to_fetch_bus_t prefetch_to_fetch_bus2,
    input  logic                   ds_allowin,
    input  logic                   icache_addr_ok,
    input  logic                   icache_data_ok,
    input  uint32_t                icache_rdata1,
    input  uint32_t                icache_rdata2,
    input  logic                   br_taken,
    input  virt_t                  br_target,
    input  bht_entry_t             bpu_entry,
    input  logic                   inst_tlb_ex,
    input  logic [4:0]             inst_tlb_exccode,
    input  logic                   inst_tlb_refill,
    input  virt_t                  flush_target,
    output logic                   fs_allowin,
    output logic                   fs_to_valid,
    output fetch_to_bpu_bus_t      fetch_to_bpu_bus,
    output redirect_t              redirect,
    output fetch_to_decode_bus_t   fetch_to_decode_bus1,
    output fetch_to_decode_bus_t   fetch_to_decode_bus2
);

    fetch_queue_entry_t fetch_queue [8];
    logic [2:0] fetch_queue_head;
    logic [2:0] fetch_queue_tail;
    logic [2:0] inst_fetch_tail;
    logic [2:0] fetch_queue_head_next;
    logic [2:0] fetch_queue_tail_next;
    logic [2:0] inst_fetch_tail_next;
    logic [3:0] fetch_queue_num;

    // replies in flight, and how many of them belong to a flushed stream
    logic [2:0] inflight;
    logic [2:0] inflight_next;
    logic [2:0] cancel_cnt;
    logic       data_cancel;

    logic fs_epoch;
    logic delay_pair;
    logic wait_bd;
    logic pending;
    logic ex_done;
    logic data_done;
    logic complete;
    logic keep1;
    logic keep2;
    logic accept;
    logic pop;
    logic br_hit;
    logic next_issued;
    logic br_op1;
    logic br_op2;

    fetch_queue_entry_t wait1;
    fetch_queue_entry_t wait2;
    fetch_queue_entry_t head1;
    fetch_queue_entry_t head2;
    exception_t         exception1;
    exception_t         exception2;

    function automatic fetch_queue_entry_t new_entry(prefetch_to_fetch_bus_t b);
        fetch_queue_entry_t e;
        e           = '0;
        e.valid     = b.valid;
        e.state     = Fetch_Wait;
        e.pc        = b.pc;
        e.exception = b.exception;
        e.epoch     = b.epoch;
        return e;
    endfunction

    function automatic fetch_queue_entry_t finish(fetch_queue_entry_t e, uint32_t inst,
                                                  logic keep, logic slot2);
        fetch_queue_entry_t r;
        r           = e;
        r.state     = Fetch_Complete;
        r.valid     = e.valid && keep;
        r.inst      = '0;
        r.br_taken  = 1'b0;
        r.bpu_entry = bpu_entry;
        if (!e.exception.ex && inst_tlb_ex) begin
            r.exception.ex         = 1'b1;
            r.exception.exccode    = inst_tlb_exccode;
            r.exception.tlb_refill = inst_tlb_refill;
        end else if (!e.exception.ex) begin
            r.inst     = inst;
            r.br_taken = br_taken && bpu_entry.inst2 == slot2;
        end
        return r;
    endfunction

    assign fetch_queue_head_next = fetch_queue_head + 3'd1;
    assign fetch_queue_tail_next = fetch_queue_tail + 3'd1;
    assign inst_fetch_tail_next  = inst_fetch_tail + 3'd1;

    assign wait1 = fetch_queue[inst_fetch_tail];
    assign wait2 = fetch_queue[inst_fetch_tail_next];
    assign head1 = fetch_queue[fetch_queue_head];
    assign head2 = fetch_queue[fetch_queue_head_next];

    assign pending     = inst_fetch_tail != fetch_queue_tail;
    assign data_cancel = cancel_cnt != 3'd0;
    assign ex_done     = pending && wait1.exception.ex;
    assign data_done   = pending && !wait1.exception.ex && icache_data_ok && !data_cancel;
    assign complete    = ex_done || data_done;

    // stale pairs complete empty, the delay pair keeps only slot one
    assign keep1 = wait1.epoch == fs_epoch || delay_pair;
    assign keep2 = wait1.epoch == fs_epoch && !delay_pair;

    assign accept        = pfs_to_valid && icache_addr_ok && !prefetch_to_fetch_bus2.exception.ex;
    assign inflight_next = inflight + {2'b00, accept} - {2'b00, icache_data_ok};

    assign fs_allowin  = fetch_queue_num <= 4'd4;
    assign fs_to_valid = fetch_queue_num != 4'd0 && head1.state == Fetch_Complete;
    assign pop         = fs_to_valid && ds_allowin;

    assign fetch_to_bpu_bus.valid = pending && !wait1.exception.ex;
    assign fetch_to_bpu_bus.pc    = {wait1.pc[31:3], 3'b000};

    assign br_hit = data_done && !inst_tlb_ex && keep2 && br_taken
                 && (bpu_entry.inst2 ? wait2.valid : wait1.valid);

    // the pair after the branch is queued already or enters this cycle
    assign next_issued = inst_fetch_tail_next + 3'd1 != fetch_queue_tail || pfs_to_valid;

    assign redirect.valid      = flush || br_hit;
    assign redirect.target     = flush ? flush_target : br_target;
    assign redirect.from_slot2 = !flush && bpu_entry.inst2 && !next_issued;

    always_ff @(posedge clk) begin
        if (pfs_to_valid) begin
            fetch_queue[fetch_queue_tail]      <= new_entry(prefetch_to_fetch_bus1);
            fetch_queue[fetch_queue_tail_next] <= new_entry(prefetch_to_fetch_bus2);
        end
        if (complete) begin
            fetch_queue[inst_fetch_tail]      <= finish(wait1, icache_rdata1, keep1, 1'b0);
            fetch_queue[inst_fetch_tail_next] <= finish(wait2, icache_rdata2, keep2, 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fetch_queue_head <= '0;
            fetch_queue_tail <= '0;
            inst_fetch_tail  <= '0;
            fetch_queue_num  <= '0;
            delay_pair       <= 1'b0;
            wait_bd          <= 1'b0;
        end else begin
            if (pfs_to_valid)
                fetch_queue_tail <= fetch_queue_tail + 3'd2;
            if (complete)
                inst_fetch_tail <= inst_fetch_tail + 3'd2;
            if (pop)
                fetch_queue_head <= fetch_queue_head + 3'd2;
            fetch_queue_num <= fetch_queue_num + (pfs_to_valid ? 4'd2 : 4'd0)
                                               - (pop ? 4'd2 : 4'd0);

            if (br_hit)
                delay_pair <= bpu_entry.inst2;
            else if (complete)
                delay_pair <= 1'b0;

            // branch in slot two, its delay slot heads the next pair
            if (pop)
                wait_bd <= br_op2 && head2.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inflight   <= '0;
            cancel_cnt <= '0;
            fs_epoch   <= 1'b0;
        end else begin
            inflight <= inflight_next;
            if (flush)
                cancel_cnt <= inflight_next;
            else if (icache_data_ok && data_cancel)
                cancel_cnt <= cancel_cnt - 3'd1;
            if (redirect.valid)
                fs_epoch <= !fs_epoch;
        end
    end

    fast_decode u_fast_decode1 (
        .inst  (head1.inst),
        .br_op (br_op1)
    );

    fast_decode u_fast_decode2 (
        .inst  (head2.inst),
        .br_op (br_op2)
    );

    always_comb begin
        exception1 = head1.exception;
        exception2 = head2.exception;
        if (wait_bd) begin
            exception1.bd  = 1'b1;
            exception1.epc = head1.pc - 32'd4;
        end
        if (br_op1 && head1.valid) begin
            exception2.bd  = 1'b1;
            exception2.epc = head2.pc - 32'd4;
        end
    end

    assign fetch_to_decode_bus1 = '{valid:     fs_to_valid && head1.valid,
                                    pc:        head1.pc,
                                    inst:      head1.inst,
                                    br_taken:  head1.br_taken,
                                    bpu_entry: head1.bpu_entry,
                                    exception: exception1};

    assign fetch_to_decode_bus2 = '{valid:     fs_to_valid && head2.valid,
                                    pc:        head2.pc,
                                    inst:      head2.inst,
                                    br_taken:  head2.br_taken,
                                    bpu_entry: head2.bpu_entry,
                                    exception: exception2};

endmodule

/* logic/frontend_top.sv */
`timescale 1ns/100ps

module frontend_top import frontend_pkg::*; #(
    parameter virt_t RESET_PC    = 32'hbfc0_0000,
    parameter int    BHT_ENTRIES = 64
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  virt_t                flush_target,
    input  logic                 icache_addr_ok,
    input  logic                 icache_data_ok,
    input  uint32_t              icache_rdata1,
    input  uint32_t              icache_rdata2,
    input  logic                 inst_tlb_ex,
    input  logic [4:0]           inst_tlb_exccode,
    input  logic                 inst_tlb_refill,
    input  bpu_update_t          bpu_update,
    input  logic                 ds_allowin,
    output logic                 icache_req,
    output virt_t                icache_addr,
    output logic                 fs_to_valid,
    output fetch_to_decode_bus_t fetch_to_decode_bus1,
    output fetch_to_decode_bus_t fetch_to_decode_bus2
);

    logic                   fs_allowin;
    logic                   pfs_to_valid;
    logic                   br_taken;
    virt_t                  br_target;
    bht_entry_t             bpu_entry;
    redirect_t              redirect;
    fetch_to_bpu_bus_t      fetch_to_bpu_bus;
    prefetch_to_fetch_bus_t prefetch_to_fetch_bus1;
    prefetch_to_fetch_bus_t prefetch_to_fetch_bus2;

    prefetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_prefetch_stage (
        .clk                    (clk),
        .reset                  (reset),
        .fs_allowin             (fs_allowin),
        .redirect               (redirect),
        .icache_addr_ok         (icache_addr_ok),
        .icache_req             (icache_req),
        .icache_addr            (icache_addr),
        .pfs_to_valid           (pfs_to_valid),
        .prefetch_to_fetch_bus1 (prefetch_to_fetch_bus1),
        .prefetch_to_fetch_bus2 (prefetch_to_fetch_bus2)
    );

    fetch_stage u_fetch_stage (
        .clk                    (clk),
        .reset                  (reset),
        .flush                  (flush),
        .pfs_to_valid           (pfs_to_valid),
        .prefetch_to_fetch_bus1 (prefetch_to_fetch_bus1),
        .prefetch_to_fetch_bus2 (prefetch_to_fetch_bus2),
        .ds_allowin             (ds_allowin),
        .icache_addr_ok         (icache_addr_ok),
        .icache_data_ok         (icache_data_ok),
        .icache_rdata1          (icache_rdata1),
        .icache_rdata2          (icache_rdata2),
        .br_taken               (br_taken),
        .br_target              (br_target),
        .bpu_entry              (bpu_entry),
        .inst_tlb_ex            (inst_tlb_ex),
        .inst_tlb_exccode       (inst_tlb_exccode),
        .inst_tlb_refill        (inst_tlb_refill),
        .flush_target           (flush_target),
        .fs_allowin             (fs_allowin),
        .fs_to_valid            (fs_to_valid),
        .fetch_to_bpu_bus       (fetch_to_bpu_bus),
        .redirect               (redirect),
        .fetch_to_decode_bus1   (fetch_to_decode_bus1),
        .fetch_to_decode_bus2   (fetch_to_decode_bus2)
    );

    branch_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) u_branch_predictor (
        .clk              (clk),
        .reset            (reset),
        .fetch_to_bpu_bus (fetch_to_bpu_bus),
        .bpu_update       (bpu_update),
        .br_taken         (br_taken),
        .br_target        (br_target),
        .bpu_entry        (bpu_entry)
    );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = !clk;
    end

endmodule

/* dv/frontend_tb.sv */
`timescale 1ns/100ps

module frontend_tb import frontend_pkg::*;;

    localparam virt_t      RESET_PC = 32'hbfc0_0000;
    localparam logic [4:0] EXC_TLBL = 5'h02;

    // trained branches in slot one and slot two
    localparam virt_t BR_A  = 32'hbfc0_0040;
    localparam virt_t TGT_A = 32'hbfc0_0204;
    localparam virt_t BR_B  = 32'hbfc0_022c;
    localparam virt_t TGT_B = 32'hbfc0_0100;

    localparam int P_SEQ   = 80;
    localparam int P_TLB   = 24;
    localparam int P_FLUSH = 30;
    localparam int P_ADEL  = 6;
    localparam int P_LOOP  = 40;
    localparam int TOTAL   = P_SEQ + P_TLB + P_FLUSH + P_ADEL + P_LOOP;
    localparam int LIMIT   = 40 * TOTAL + 1000;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    virt_t                flush_target;
    logic                 icache_addr_ok;
    logic                 icache_data_ok;
    uint32_t              icache_rdata1;
    uint32_t              icache_rdata2;
    logic                 inst_tlb_ex;
    logic [4:0]           inst_tlb_exccode;
    logic                 inst_tlb_refill;
    bpu_update_t          bpu_update;
    logic                 ds_allowin;
    logic                 icache_req;
    virt_t                icache_addr;
    logic                 fs_to_valid;
    fetch_to_decode_bus_t fetch_to_decode_bus1;
    fetch_to_decode_bus_t fetch_to_decode_bus2;

    int    seed = 32'h6cfda253;
    int    cyc;
    int    consumed;
    virt_t expected_next;
    logic  in_adel;
    logic  trained;
    logic  jump_due;
    virt_t due_addr;
    virt_t addr_q[$];
    int    ready_q[$];

    // reference model state
    virt_t m_pc;
    logic  m_prev_br;
    logic  m_in_delay;
    virt_t m_target;

    tb_clock #(.PERIOD_NS(100)) u_tb_clock (.clk(clk));

    frontend_top #(
        .RESET_PC    (RESET_PC),
        .BHT_ENTRIES (64)
    ) dut_i (
        .clk                  (clk),
        .reset                (reset),
        .flush                (flush),
        .flush_target         (flush_target),
        .icache_addr_ok       (icache_addr_ok),
        .icache_data_ok       (icache_data_ok),
        .icache_rdata1        (icache_rdata1),
        .icache_rdata2        (icache_rdata2),
        .inst_tlb_ex          (inst_tlb_ex),
        .inst_tlb_exccode     (inst_tlb_exccode),
        .inst_tlb_refill      (inst_tlb_refill),
        .bpu_update           (bpu_update),
        .ds_allowin           (ds_allowin),
        .icache_req           (icache_req),
        .icache_addr          (icache_addr),
        .fs_to_valid          (fs_to_valid),
        .fetch_to_decode_bus1 (fetch_to_decode_bus1),
        .fetch_to_decode_bus2 (fetch_to_decode_bus2)
    );

    // opcode 001xxx everywhere except the two beq words
    function automatic uint32_t mem_word(virt_t a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ {a[15:0], a[31:16]};
        if (a == BR_A || a == BR_B)
            return {6'b000100, h[25:0]};
        return {3'b001, h[28:0]};
    endfunction

    function automatic logic in_fault_page(virt_t a);
        return a[31:12] == 20'hbfc01;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_request(input string name, input virt_t exp, input virt_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    endtask

    // only the predicted target of a taken slot is modeled
    task automatic check_decode(input string name, input fetch_to_decode_bus_t exp,
                                input fetch_to_decode_bus_t act);
        fetch_to_decode_bus_t e;
        fetch_to_decode_bus_t a;
        e = exp;
        a = act;
        e.bpu_entry = '0;
        a.bpu_entry = '0;
        if (a !== e)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, e, a));
    endtask

    task automatic expect_slot(output fetch_to_decode_bus_t e);
        virt_t pc;
        logic  br;
        logic  taken;
        pc    = m_pc;
        br    = pc == BR_A || pc == BR_B;
        taken = br && trained;
        e = '0;
        e.valid         = 1'b1;
        e.pc            = pc;
        e.exception.bd  = m_prev_br;
        e.exception.epc = m_prev_br ? pc - 32'd4 : pc;
        if (pc[1:0] != 2'b00) begin
            e.exception.ex      = 1'b1;
            e.exception.exccode = EXC_ADEL;
        end else if (in_fault_page(pc)) begin
            e.exception.ex         = 1'b1;
            e.exception.exccode    = EXC_TLBL;
            e.exception.tlb_refill = pc[4];
        end else begin
            e.inst     = mem_word(pc);
            e.br_taken = taken;
        end
        // branch, delay slot, then the target
        if (m_in_delay) begin
            m_pc       = m_target;
            m_in_delay = 1'b0;
        end else begin
            m_pc       = pc + 32'd4;
            m_in_delay = taken;
            m_target   = pc == BR_A ? TGT_A : TGT_B;
        end
        m_prev_br = br;
    endtask

    task automatic consume(input fetch_to_decode_bus_t act);
        fetch_to_decode_bus_t e;
        expect_slot(e);
        check_decode($sformatf("decode slot %0d", consumed), e, act);
        if (e.br_taken)
            check_request("predicted target", e.pc == BR_A ? TGT_A : TGT_B,
                          act.bpu_entry.target);
        consumed++;
    endtask

    // one cycle of stimulus on the falling edge
    task automatic step(input logic do_flush, input virt_t target);
        logic [31:0] r;
        virt_t       a;
        cyc++;
        if (cyc > LIMIT)
            abort_run("timeout: decode slots stopped arriving");
        r = $random(seed);
        bpu_update     = '0;
        ds_allowin     = !do_flush && r[1:0] != 2'b00;
        icache_addr_ok = r[3:2] != 2'b00;

        if (in_adel && icache_req)
            abort_run("cache request issued for a misaligned pair");

        if (fs_to_valid && ds_allowin) begin
            if (fetch_to_decode_bus1.valid)
                consume(fetch_to_decode_bus1);
            if (fetch_to_decode_bus2.valid)
                consume(fetch_to_decode_bus2);
        end

        if (icache_req && icache_addr_ok) begin
            if (jump_due && icache_addr == due_addr) begin
                expected_next = icache_addr;
                jump_due      = 1'b0;
            end
            check_request("request address", expected_next, icache_addr);
            expected_next = icache_addr + 32'd8;
            // a trained branch pair sends the stream to its target later
            if (trained && icache_addr == {BR_A[31:3], 3'b000}) begin
                jump_due = 1'b1;
                due_addr = {TGT_A[31:3], 3'b000};
            end else if (trained && icache_addr == {BR_B[31:3], 3'b000}) begin
                jump_due = 1'b1;
                due_addr = {TGT_B[31:3], 3'b000};
            end
            addr_q.push_back(icache_addr);
            ready_q.push_back(cyc + 1 + int'(r[5:4]));
        end

        if (addr_q.size() != 0 && ready_q[0] <= cyc) begin
            a = addr_q.pop_front();
            void'(ready_q.pop_front());
            icache_data_ok   = 1'b1;
            icache_rdata1    = mem_word(a);
            icache_rdata2    = mem_word(a + 32'd4);
            inst_tlb_ex      = in_fault_page(a);
            inst_tlb_exccode = in_fault_page(a) ? EXC_TLBL : 5'h00;
            inst_tlb_refill  = in_fault_page(a) && a[4];
        end else begin
            icache_data_ok   = 1'b0;
            icache_rdata1    = '0;
            icache_rdata2    = '0;
            inst_tlb_ex      = 1'b0;
            inst_tlb_exccode = 5'h00;
            inst_tlb_refill  = 1'b0;
        end

        flush        = do_flush;
        flush_target = do_flush ? target : '0;
        if (do_flush) begin
            m_pc          = target;
            m_prev_br     = 1'b0;
            m_in_delay    = 1'b0;
            expected_next = {target[31:3], 3'b000};
            in_adel       = target[1:0] != 2'b00;
            jump_due      = 1'b0;
        end
    endtask

    // one taken update leaves the counter at 2
    task automatic train_branch(input virt_t pc, input virt_t target);
        @(negedge clk);
        step(1'b0, '0);
        bpu_update = '{valid: 1'b1, pc: pc, target: target, taken: 1'b1};
    endtask

    task automatic run_phase(input logic do_flush, input virt_t target, input int nslots);
        int goal;
        goal = consumed + nslots;
        if (do_flush) begin
            @(negedge clk);
            step(1'b1, target);
        end
        while (consumed < goal) begin
            @(negedge clk);
            step(1'b0, '0);
        end
    endtask

    initial begin
        reset            = 1'b1;
        flush            = 1'b0;
        flush_target     = '0;
        icache_addr_ok   = 1'b0;
        icache_data_ok   = 1'b0;
        icache_rdata1    = '0;
        icache_rdata2    = '0;
        inst_tlb_ex      = 1'b0;
        inst_tlb_exccode = 5'h00;
        inst_tlb_refill  = 1'b0;
        bpu_update       = '0;
        ds_allowin       = 1'b0;
        cyc              = 0;
        consumed         = 0;
        in_adel          = 1'b0;
        trained          = 1'b0;
        jump_due         = 1'b0;
        due_addr         = '0;
        expected_next    = RESET_PC;
        m_pc             = RESET_PC;
        m_prev_br        = 1'b0;
        m_in_delay       = 1'b0;
        m_target         = '0;

        repeat (8) @(negedge clk);
        reset = 1'b0;

        run_phase(1'b0, '0, P_SEQ);
        run_phase(1'b1, 32'hbfc0_1000, P_TLB);
        run_phase(1'b1, 32'hbfc0_0600, P_FLUSH);
        run_phase(1'b1, 32'hbfc0_0702, P_ADEL);

        train_branch(BR_A, TGT_A);
        train_branch(BR_B, TGT_B);
        trained = 1'b1;
        run_phase(1'b1, 32'hbfc0_0004, P_LOOP);

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* all.f */
logic/frontend_pkg.sv
logic/fast_decode.sv
logic/branch_predictor.sv
logic/prefetch_stage.sv
logic/fetch_stage.sv
logic/frontend_top.sv
dv/tb_clock.sv
dv/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
